// File: Makefile
# Verilator build and run for the row address generator

VERILATOR ?= verilator
TOP       ?= conv_row_adr_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not from the exit code of the binary
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/conv_cfg_regs.sv
`timescale 1ns/1ps

module conv_cfg_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  // APB slave
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [7:0]             paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  // Sequencer handshake
  input  logic                   busy,
  output logic                   start,
  // Layer geometry
  output conv_shell_pkg::small_t stride,
  output conv_shell_pkg::small_t pad,
  output conv_shell_pkg::dim_t   iy,
  output conv_shell_pkg::dim_t   poy,
  output conv_shell_pkg::dim_t   iy_start,
  output conv_shell_pkg::dim_t   ky_count,
  output conv_shell_pkg::dim_t   if_count,
  output conv_shell_pkg::log2_t  nif_log2,
  output conv_shell_pkg::log2_t  ix_log2
);

  localparam logic [7:0] ADR_CTRL     = 8'h00;
  localparam logic [7:0] ADR_STATUS   = 8'h04;
  localparam logic [7:0] ADR_STRIDE   = 8'h08;
  localparam logic [7:0] ADR_IY       = 8'h0C;
  localparam logic [7:0] ADR_POY      = 8'h10;
  localparam logic [7:0] ADR_IY_START = 8'h14;
  localparam logic [7:0] ADR_KY_COUNT = 8'h18;
  localparam logic [7:0] ADR_SHAPE    = 8'h1C;
  localparam logic [7:0] ADR_IF_COUNT = 8'h20;

  logic wr_en;

  // No wait states
  assign pready = 1'b1;

  assign wr_en = psel && penable && pwrite;

  // Start pulse lasts the single access cycle, dropped while busy
  assign start = wr_en && (paddr == ADR_CTRL) && pwdata[0] && !busy;

  ////////////////////////////////////////////////////////////
  // Geometry registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stride   <= '0;
      pad      <= '0;
      iy       <= '0;
      poy      <= '0;
      iy_start <= '0;
      ky_count <= conv_shell_pkg::dim_t'(1);
      if_count <= conv_shell_pkg::dim_t'(1);
      nif_log2 <= '0;
      ix_log2  <= '0;
    end else if (wr_en) begin
      case (paddr)
        ADR_STRIDE: begin
          stride <= pwdata[3:0];
          pad    <= pwdata[7:4];
        end
        ADR_IY:       iy       <= pwdata[15:0];
        ADR_POY:      poy      <= pwdata[15:0];
        ADR_IY_START: iy_start <= pwdata[15:0];
        ADR_KY_COUNT: ky_count <= pwdata[15:0];
        ADR_SHAPE: begin
          nif_log2 <= pwdata[3:0];
          ix_log2  <= pwdata[7:4];
        end
        ADR_IF_COUNT: if_count <= pwdata[15:0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    prdata = '0;
    case (paddr)
      ADR_STATUS:   prdata = {31'd0, busy};
      ADR_STRIDE:   prdata = {24'd0, pad, stride};
      ADR_IY:       prdata = {16'd0, iy};
      ADR_POY:      prdata = {16'd0, poy};
      ADR_IY_START: prdata = {16'd0, iy_start};
      ADR_KY_COUNT: prdata = {16'd0, ky_count};
      ADR_SHAPE:    prdata = {24'd0, ix_log2, nif_log2};
      ADR_IF_COUNT: prdata = {16'd0, if_count};
      // Control reads as zero, start never holds
      default:      prdata = '0;
    endcase
  end

endmodule

// File: design/conv_row_adr_top.sv
`timescale 1ns/1ps

module conv_row_adr_top #(
  parameter int PIX_ROW_LOG2 = conv_shell_pkg::PIX_ROW_LOG2,
  parameter int IBUF_LOG2    = conv_shell_pkg::IBUF_LOG2,
  parameter int SLAB_LOG2    = conv_shell_pkg::SLAB_LOG2
) (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  // APB configuration port
  input  logic                                                 psel,
  input  logic                                                 penable,
  input  logic                                                 pwrite,
  input  logic [7:0]                                           paddr,
  input  logic [31:0]                                          pwdata,
  output logic [31:0]                                          prdata,
  output logic                                                 pready,
  // Address stream
  input  logic                                                 adr_ready,
  output logic                                                 adr_valid,
  output conv_shell_pkg::dim_t                                 out_ky,
  output conv_shell_pkg::dim_t                                 out_if_start,
  output conv_shell_pkg::dim_t     [conv_shell_pkg::LANES-1:0] row_idx,
  output conv_shell_pkg::buf_sel_t [conv_shell_pkg::LANES-1:0] buf_sel,
  output conv_shell_pkg::adr_t     [conv_shell_pkg::LANES-1:0] buf_adr,
  output logic                     [conv_shell_pkg::LANES-1:0] word_sel,
  output conv_shell_pkg::adr_t     [conv_shell_pkg::LANES-1:0] slab_adr,
  output logic                     [conv_shell_pkg::LANES-1:0] lane_valid
);

  conv_shell_pkg::small_t stride;
  conv_shell_pkg::small_t pad;
  conv_shell_pkg::dim_t   iy;
  conv_shell_pkg::dim_t   poy;
  conv_shell_pkg::dim_t   iy_start;
  conv_shell_pkg::dim_t   ky_count;
  conv_shell_pkg::dim_t   if_count;
  conv_shell_pkg::log2_t  nif_log2;
  conv_shell_pkg::log2_t  ix_log2;
  logic                   start;
  logic                   busy;
  logic                   stage_empty;

  row_req_if req_if ();

  conv_cfg_regs u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .busy     (busy),
    .start    (start),
    .stride   (stride),
    .pad      (pad),
    .iy       (iy),
    .poy      (poy),
    .iy_start (iy_start),
    .ky_count (ky_count),
    .if_count (if_count),
    .nif_log2 (nif_log2),
    .ix_log2  (ix_log2)
  );

  row_window_seq u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .ky_count    (ky_count),
    .if_count    (if_count),
    .stage_empty (stage_empty),
    .busy        (busy),
    .req         (req_if.src)
  );

  row_adr_stage #(
    .PIX_ROW_LOG2 (PIX_ROW_LOG2),
    .IBUF_LOG2    (IBUF_LOG2),
    .SLAB_LOG2    (SLAB_LOG2)
  ) u_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .stride       (stride),
    .pad          (pad),
    .iy           (iy),
    .poy          (poy),
    .iy_start     (iy_start),
    .nif_log2     (nif_log2),
    .ix_log2      (ix_log2),
    .req          (req_if.dst),
    .adr_ready    (adr_ready),
    .adr_valid    (adr_valid),
    .stage_empty  (stage_empty),
    .out_ky       (out_ky),
    .out_if_start (out_if_start),
    .row_idx      (row_idx),
    .buf_sel      (buf_sel),
    .buf_adr      (buf_adr),
    .word_sel     (word_sel),
    .slab_adr     (slab_adr),
    .lane_valid   (lane_valid)
  );

endmodule

// File: design/conv_shell_pkg.sv
package conv_shell_pkg;

  ////////////////////////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////////////////////////

  // Row count, row index or feature index
  typedef logic [15:0] dim_t;

  // Buffer word address, all ones means no access
  typedef logic [15:0] adr_t;

  // Exponent of a power-of-two size
  typedef logic [3:0] log2_t;

  // Stride or padding
  typedef logic [3:0] small_t;

  // Line buffer index, 1 to 3 select a buffer and 0 is none
  typedef logic [1:0] buf_sel_t;

  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,
    SEQ_RUN   = 2'd1,
    SEQ_DRAIN = 2'd2
  } seq_state_t;

  ////////////////////////////////////////////////////////////
  // Shell constants and default sizes
  ////////////////////////////////////////////////////////////

  // Window rows per compute shell
  localparam int LANES = 3;

  localparam int PIX_ROW_LOG2 = 5;
  localparam int IBUF_LOG2    = 12;
  localparam int SLAB_LOG2    = 13;

  localparam adr_t INVALID_ADR = '1;

endpackage

// File: design/row_adr_stage.sv
`timescale 1ns/1ps

module row_adr_stage #(
  parameter int PIX_ROW_LOG2 = conv_shell_pkg::PIX_ROW_LOG2,
  parameter int IBUF_LOG2    = conv_shell_pkg::IBUF_LOG2,
  parameter int SLAB_LOG2    = conv_shell_pkg::SLAB_LOG2
) (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  conv_shell_pkg::small_t                               stride,
  input  conv_shell_pkg::small_t                               pad,
  input  conv_shell_pkg::dim_t                                 iy,
  input  conv_shell_pkg::dim_t                                 poy,
  input  conv_shell_pkg::dim_t                                 iy_start,
  input  conv_shell_pkg::log2_t                                nif_log2,
  input  conv_shell_pkg::log2_t                                ix_log2,
  row_req_if.dst                                               req,
  input  logic                                                 adr_ready,
  output logic                                                 adr_valid,
  output logic                                                 stage_empty,
  output conv_shell_pkg::dim_t                                 out_ky,
  output conv_shell_pkg::dim_t                                 out_if_start,
  output conv_shell_pkg::dim_t     [conv_shell_pkg::LANES-1:0] row_idx,
  output conv_shell_pkg::buf_sel_t [conv_shell_pkg::LANES-1:0] buf_sel,
  output conv_shell_pkg::adr_t     [conv_shell_pkg::LANES-1:0] buf_adr,
  output logic                     [conv_shell_pkg::LANES-1:0] word_sel,
  output conv_shell_pkg::adr_t     [conv_shell_pkg::LANES-1:0] slab_adr,
  output logic                     [conv_shell_pkg::LANES-1:0] lane_valid
);

  conv_shell_pkg::dim_t     [conv_shell_pkg::LANES-1:0] tr_row_idx;
  conv_shell_pkg::buf_sel_t [conv_shell_pkg::LANES-1:0] tr_buf_sel;
  conv_shell_pkg::adr_t     [conv_shell_pkg::LANES-1:0] tr_buf_adr;
  logic                     [conv_shell_pkg::LANES-1:0] tr_word_sel;
  conv_shell_pkg::adr_t     [conv_shell_pkg::LANES-1:0] tr_slab_adr;
  logic                     [conv_shell_pkg::LANES-1:0] tr_lane_valid;
  logic                                                 accept;

  for (genvar k = 0; k < conv_shell_pkg::LANES; k++) begin : g_lane
    row_adr_translate #(
      .LANE         (k),
      .PIX_ROW_LOG2 (PIX_ROW_LOG2),
      .IBUF_LOG2    (IBUF_LOG2),
      .SLAB_LOG2    (SLAB_LOG2)
    ) u_translate (
      .stride     (stride),
      .pad        (pad),
      .iy         (iy),
      .poy        (poy),
      .iy_start   (iy_start),
      .nif_log2   (nif_log2),
      .ix_log2    (ix_log2),
      .ky         (req.ky),
      .if_start   (req.if_start),
      .row_idx    (tr_row_idx[k]),
      .buf_sel    (tr_buf_sel[k]),
      .buf_adr    (tr_buf_adr[k]),
      .word_sel   (tr_word_sel[k]),
      .slab_adr   (tr_slab_adr[k]),
      .lane_valid (tr_lane_valid[k])
    );
  end

  // Register is free or drains this cycle
  assign req.ready   = !adr_valid || adr_ready;
  assign stage_empty = !adr_valid || adr_ready;
  assign accept      = req.valid && req.ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      adr_valid <= 1'b0;
    end else if (req.ready) begin
      adr_valid <= req.valid;
    end
  end

  // Payload held while stalled
  always_ff @(posedge clk) begin
    if (accept) begin
      out_ky       <= req.ky;
      out_if_start <= req.if_start;
      row_idx      <= tr_row_idx;
      buf_sel      <= tr_buf_sel;
      buf_adr      <= tr_buf_adr;
      word_sel     <= tr_word_sel;
      slab_adr     <= tr_slab_adr;
      lane_valid   <= tr_lane_valid;
    end
  end

endmodule

// File: design/row_adr_translate.sv
`timescale 1ns/1ps

module row_adr_translate #(
  parameter int LANE         = 0,
  parameter int PIX_ROW_LOG2 = conv_shell_pkg::PIX_ROW_LOG2,
  parameter int IBUF_LOG2    = conv_shell_pkg::IBUF_LOG2,
  parameter int SLAB_LOG2    = conv_shell_pkg::SLAB_LOG2
) (
  input  conv_shell_pkg::small_t   stride,
  input  conv_shell_pkg::small_t   pad,
  input  conv_shell_pkg::dim_t     iy,
  input  conv_shell_pkg::dim_t     poy,
  input  conv_shell_pkg::dim_t     iy_start,
  input  conv_shell_pkg::log2_t    nif_log2,
  input  conv_shell_pkg::log2_t    ix_log2,
  input  conv_shell_pkg::dim_t     ky,
  input  conv_shell_pkg::dim_t     if_start,
  output conv_shell_pkg::dim_t     row_idx,
  output conv_shell_pkg::buf_sel_t buf_sel,
  output conv_shell_pkg::adr_t     buf_adr,
  output logic                     word_sel,
  output conv_shell_pkg::adr_t     slab_adr,
  output logic                     lane_valid
);

  localparam conv_shell_pkg::dim_t LANE_OFS = conv_shell_pkg::dim_t'(LANE);

  conv_shell_pkg::dim_t raw;
  conv_shell_pkg::dim_t pad_w;
  conv_shell_pkg::dim_t rel;
  conv_shell_pkg::dim_t rel_m1;
  conv_shell_pkg::dim_t buf_row;
  conv_shell_pkg::dim_t if_m1;
  conv_shell_pkg::adr_t ibuf_mask;
  conv_shell_pkg::adr_t slab_mask;
  logic [2:0]           rem;
  logic [4:0]           slab_sh;
  logic [4:0]           ibuf_sh;
  logic [4:0]           ibuf_bits;
  logic [4:0]           slab_bits;

  assign pad_w = conv_shell_pkg::dim_t'(pad);
  assign raw   = iy_start + ky + LANE_OFS * conv_shell_pkg::dim_t'(stride);

  // Lane inside the output rows and the row inside the unpadded window
  assign lane_valid = (poy > LANE_OFS) && (raw >= pad_w + conv_shell_pkg::dim_t'(1)) &&
                      (raw <= pad_w + iy);

  assign rel    = raw - pad_w;
  assign rel_m1 = rel - conv_shell_pkg::dim_t'(1);
  assign if_m1  = if_start - conv_shell_pkg::dim_t'(1);

  // Divide by three, one compare per bit
  always_comb begin
    rem     = '0;
    buf_row = '0;
    for (int i = 15; i >= 0; i--) begin
      rem = {rem[1:0], rel_m1[i]};
      if (rem >= 3'd3) begin
        rem        = rem - 3'd3;
        buf_row[i] = 1'b1;
      end
    end
  end

  // Two features share a word in the input buffer
  assign slab_sh   = 5'(nif_log2) + 5'(ix_log2) - 5'(PIX_ROW_LOG2);
  assign ibuf_sh   = slab_sh - 5'd1;
  assign ibuf_bits = 5'(IBUF_LOG2) - ibuf_sh;
  assign slab_bits = 5'(SLAB_LOG2) - slab_sh;
  assign ibuf_mask = conv_shell_pkg::adr_t'((17'd1 << ibuf_bits) - 17'd1);
  assign slab_mask = conv_shell_pkg::adr_t'((17'd1 << slab_bits) - 17'd1);

  assign row_idx  = lane_valid ? rel : conv_shell_pkg::INVALID_ADR;
  assign buf_sel  = lane_valid ? conv_shell_pkg::buf_sel_t'(rem[1:0] + 2'd1) : '0;
  assign word_sel = lane_valid && if_m1[0];
  assign buf_adr  = lane_valid ? ((buf_row & ibuf_mask) << ibuf_sh) + (if_m1 >> 1)
                               : conv_shell_pkg::INVALID_ADR;
  assign slab_adr = lane_valid ? ((buf_row & slab_mask) << slab_sh) + if_m1
                               : conv_shell_pkg::INVALID_ADR;

endmodule

// File: design/row_req_if.sv
`timescale 1ns/1ps

// One window step, sequencer to address stage
interface row_req_if;

  logic                 valid;
  logic                 ready;
  conv_shell_pkg::dim_t ky;
  // Feature group, counted from 1
  conv_shell_pkg::dim_t if_start;
  // Final step of the pass
  logic                 last;

  modport src (
    output valid,
    output ky,
    output if_start,
    output last,
    input  ready
  );

  modport dst (
    input  valid,
    input  ky,
    input  if_start,
    input  last,
    output ready
  );

endinterface

// File: design/row_window_seq.sv
`timescale 1ns/1ps

module row_window_seq (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  conv_shell_pkg::dim_t ky_count,
  input  conv_shell_pkg::dim_t if_count,
  input  logic                 stage_empty,
  output logic                 busy,
  row_req_if.src               req
);

  conv_shell_pkg::seq_state_t state;
  conv_shell_pkg::dim_t       ky_cnt;
  conv_shell_pkg::dim_t       if_cnt;
  logic                       ky_last;
  logic                       if_last;
  logic                       xfer;

  // Compare with >= so a zero count still ends the pass
  assign ky_last = (ky_cnt + conv_shell_pkg::dim_t'(1)) >= ky_count;
  assign if_last = if_cnt >= if_count;

  assign req.valid    = (state == conv_shell_pkg::SEQ_RUN);
  assign req.ky       = ky_cnt;
  assign req.if_start = if_cnt;
  assign req.last     = ky_last && if_last;

  assign xfer = req.valid && req.ready;

  // Busy until the final address has left the stage
  assign busy = (state != conv_shell_pkg::SEQ_IDLE);

  ////////////////////////////////////////////////////////////
  // State and window counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= conv_shell_pkg::SEQ_IDLE;
      ky_cnt <= '0;
      if_cnt <= conv_shell_pkg::dim_t'(1);
    end else begin
      case (state)
        conv_shell_pkg::SEQ_IDLE: begin
          if (start) begin
            state  <= conv_shell_pkg::SEQ_RUN;
            ky_cnt <= '0;
            if_cnt <= conv_shell_pkg::dim_t'(1);
          end
        end
        conv_shell_pkg::SEQ_RUN: begin
          if (xfer) begin
            if (req.last) begin
              state <= conv_shell_pkg::SEQ_DRAIN;
            end else if (if_last) begin
              // Feature group wraps, next kernel row
              if_cnt <= conv_shell_pkg::dim_t'(1);
              ky_cnt <= ky_cnt + conv_shell_pkg::dim_t'(1);
            end else begin
              if_cnt <= if_cnt + conv_shell_pkg::dim_t'(1);
            end
          end
        end
        conv_shell_pkg::SEQ_DRAIN: begin
          if (stage_empty) begin
            state <= conv_shell_pkg::SEQ_IDLE;
          end
        end
        default: state <= conv_shell_pkg::SEQ_IDLE;
      endcase
    end
  end

endmodule

// File: tb.f
design/conv_shell_pkg.sv
design/row_req_if.sv
design/conv_cfg_regs.sv
design/row_window_seq.sv
design/row_adr_translate.sv
design/row_adr_stage.sv
design/conv_row_adr_top.sv
verif/conv_row_adr_checker.sv
verif/conv_row_adr_tb.sv

// File: verif/conv_row_adr_checker.sv
`timescale 1ns/1ps

module conv_row_adr_checker (
  input logic                                                 clk,
  input logic                                                 rst_n,
  input logic                                                 adr_valid,
  input logic                                                 adr_ready,
  input conv_shell_pkg::dim_t                                 out_ky,
  input conv_shell_pkg::dim_t                                 out_if_start,
  input conv_shell_pkg::dim_t     [conv_shell_pkg::LANES-1:0] row_idx,
  input conv_shell_pkg::buf_sel_t [conv_shell_pkg::LANES-1:0] buf_sel,
  input conv_shell_pkg::adr_t     [conv_shell_pkg::LANES-1:0] buf_adr,
  input logic                     [conv_shell_pkg::LANES-1:0] word_sel,
  input conv_shell_pkg::adr_t     [conv_shell_pkg::LANES-1:0] slab_adr,
  input logic                     [conv_shell_pkg::LANES-1:0] lane_valid
);

  // Payload frozen while the consumer stalls
  a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
    adr_valid && !adr_ready |=> $stable({out_ky, out_if_start, row_idx, buf_sel, buf_adr,
                                         word_sel, slab_adr, lane_valid}))
    else $error("address payload changed while stalled");

  a_reset_idle: assert property (@(posedge clk) !rst_n |=> !adr_valid)
    else $error("adr_valid high after a reset cycle");

  for (genvar k = 0; k < conv_shell_pkg::LANES; k++) begin : g_lane
    a_invalid_lane: assert property (@(posedge clk) disable iff (!rst_n)
      adr_valid && !lane_valid[k] |->
        (row_idx[k] == conv_shell_pkg::INVALID_ADR) &&
        (buf_adr[k] == conv_shell_pkg::INVALID_ADR) &&
        (slab_adr[k] == conv_shell_pkg::INVALID_ADR) &&
        (buf_sel[k] == 2'd0) && !word_sel[k])
      else $error("invalid lane %0d carries an address or select", k);
  end

endmodule

bind row_adr_stage conv_row_adr_checker u_checker (
  .clk          (clk),
  .rst_n        (rst_n),
  .adr_valid    (adr_valid),
  .adr_ready    (adr_ready),
  .out_ky       (out_ky),
  .out_if_start (out_if_start),
  .row_idx      (row_idx),
  .buf_sel      (buf_sel),
  .buf_adr      (buf_adr),
  .word_sel     (word_sel),
  .slab_adr     (slab_adr),
  .lane_valid   (lane_valid)
);

// File: verif/conv_row_adr_tb.sv
`timescale 1ns/1ps

module conv_row_adr_tb;

  localparam int LANES        = conv_shell_pkg::LANES;
  localparam int PIX_ROW_LOG2 = conv_shell_pkg::PIX_ROW_LOG2;
  localparam int IBUF_LOG2    = conv_shell_pkg::IBUF_LOG2;
  localparam int SLAB_LOG2    = conv_shell_pkg::SLAB_LOG2;
  localparam int N_CFG        = 5;
  localparam int POLL_LIMIT   = 400;

  // Register map
  localparam logic [7:0] ADR_CTRL     = 8'h00;
  localparam logic [7:0] ADR_STATUS   = 8'h04;
  localparam logic [7:0] ADR_STRIDE   = 8'h08;
  localparam logic [7:0] ADR_IY       = 8'h0C;
  localparam logic [7:0] ADR_POY      = 8'h10;
  localparam logic [7:0] ADR_IY_START = 8'h14;
  localparam logic [7:0] ADR_KY_COUNT = 8'h18;
  localparam logic [7:0] ADR_SHAPE    = 8'h1C;
  localparam logic [7:0] ADR_IF_COUNT = 8'h20;

  typedef struct packed {
    logic [3:0]  stride;
    logic [3:0]  pad;
    logic [15:0] iy;
    logic [15:0] poy;
    logic [15:0] iy_start;
    logic [15:0] ky_count;
    logic [15:0] if_count;
    logic [3:0]  nif_log2;
    logic [3:0]  ix_log2;
    logic        restart;
  } layer_cfg_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        adr_ready = 1'b0;
  logic        adr_valid;

  conv_shell_pkg::dim_t                         out_ky;
  conv_shell_pkg::dim_t                         out_if_start;
  conv_shell_pkg::dim_t     [LANES-1:0]         row_idx;
  conv_shell_pkg::buf_sel_t [LANES-1:0]         buf_sel;
  conv_shell_pkg::adr_t     [LANES-1:0]         buf_adr;
  logic                     [LANES-1:0]         word_sel;
  conv_shell_pkg::adr_t     [LANES-1:0]         slab_adr;
  logic                     [LANES-1:0]         lane_valid;

  layer_cfg_t  cfg_tab [N_CFG];
  layer_cfg_t  cur;
  logic        stall_mode = 1'b0;
  logic [31:0] lfsr_state = 32'hceb6_c7af;
  int          error_count = 0;
  int          check_count = 0;

  // Steps seen on the output stream, in transfer order
  logic [15:0] q_ky [$];
  logic [15:0] q_if [$];
  logic [47:0] q_row [$];
  logic [5:0]  q_sel [$];
  logic [47:0] q_badr [$];
  logic [2:0]  q_wsel [$];
  logic [47:0] q_sadr [$];
  logic [2:0]  q_valid [$];
  logic        q_busy [$];

  conv_row_adr_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .adr_ready    (adr_ready),
    .adr_valid    (adr_valid),
    .out_ky       (out_ky),
    .out_if_start (out_if_start),
    .row_idx      (row_idx),
    .buf_sel      (buf_sel),
    .buf_adr      (buf_adr),
    .word_sel     (word_sel),
    .slab_adr     (slab_adr),
    .lane_valid   (lane_valid)
  );

  always #50 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  ////////////////////////////////////////////////////////////
  // Consumer side
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (stall_mode) begin
      lfsr_state = lfsr_step(lfsr_state);
      adr_ready <= lfsr_state[0];
    end else begin
      adr_ready <= 1'b1;
    end
  end

  // Inputs settle after the rising edge so the falling edge sees the transfer
  always @(negedge clk) begin
    if (rst_n && adr_valid && adr_ready) begin
      q_ky.push_back(out_ky);
      q_if.push_back(out_if_start);
      q_row.push_back(row_idx);
      q_sel.push_back(buf_sel);
      q_badr.push_back(buf_adr);
      q_wsel.push_back(word_sel);
      q_sadr.push_back(slab_adr);
      q_valid.push_back(lane_valid);
      q_busy.push_back(uut.busy);
    end
  end

  task automatic check_value(input string name, input logic [47:0] expected,
                             input logic [47:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t %s expected %0h got %0h", $time, name, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // APB access
  ////////////////////////////////////////////////////////////

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
    check_value("pready", 48'd1, 48'(pready));
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] expected,
                            input string name);
    logic [31:0] data;
    apb_read(addr, data);
    check_value(name, 48'(expected), 48'(data));
  endtask

  task automatic program_cfg();
    apb_write(ADR_STRIDE, {24'd0, cur.pad, cur.stride});
    apb_write(ADR_IY, {16'd0, cur.iy});
    apb_write(ADR_POY, {16'd0, cur.poy});
    apb_write(ADR_IY_START, {16'd0, cur.iy_start});
    apb_write(ADR_KY_COUNT, {16'd0, cur.ky_count});
    apb_write(ADR_SHAPE, {24'd0, cur.ix_log2, cur.nif_log2});
    apb_write(ADR_IF_COUNT, {16'd0, cur.if_count});
    read_check(ADR_STRIDE, {24'd0, cur.pad, cur.stride}, "stride_pad");
    read_check(ADR_IY, {16'd0, cur.iy}, "iy");
    read_check(ADR_POY, {16'd0, cur.poy}, "poy");
    read_check(ADR_IY_START, {16'd0, cur.iy_start}, "iy_start");
    read_check(ADR_KY_COUNT, {16'd0, cur.ky_count}, "ky_count");
    read_check(ADR_SHAPE, {24'd0, cur.ix_log2, cur.nif_log2}, "shape");
    read_check(ADR_IF_COUNT, {16'd0, cur.if_count}, "if_count");
  endtask

  task automatic wait_idle();
    logic [31:0] status;
    int          polls;
    polls  = 0;
    status = 32'd1;
    while (status[0] && polls < POLL_LIMIT) begin
      apb_read(ADR_STATUS, status);
      polls++;
    end
    if (status[0]) begin
      error_count++;
      $display("Timeout: busy still set after %0d status polls at %0t", polls, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference address rule
  ////////////////////////////////////////////////////////////

  task automatic ref_lane(input int k, input logic [15:0] ky, input logic [15:0] ifs,
                          output logic [15:0] row, output logic [1:0] sel,
                          output logic [15:0] badr, output logic wsel,
                          output logic [15:0] sadr, output logic valid);
    logic [15:0] raw;
    logic [15:0] brow;
    logic [15:0] ifm1;
    int          ssh;
    int          ish;
    raw   = cur.iy_start + ky + 16'(k) * 16'(cur.stride);
    valid = (cur.poy > 16'(k)) && (raw >= 16'(cur.pad) + 16'd1) &&
            (raw <= 16'(cur.pad) + cur.iy);
    ifm1  = ifs - 16'd1;
    ssh   = int'(cur.nif_log2) + int'(cur.ix_log2) - PIX_ROW_LOG2;
    ish   = ssh - 1;
    if (valid) begin
      row  = raw - 16'(cur.pad);
      sel  = 2'((row - 16'd1) % 16'd3) + 2'd1;
      brow = (row - 16'd1) / 16'd3;
      badr = ((brow & 16'((1 << (IBUF_LOG2 - ish)) - 1)) << ish) + (ifm1 >> 1);
      wsel = ifm1[0];
      sadr = ((brow & 16'((1 << (SLAB_LOG2 - ssh)) - 1)) << ssh) + ifm1;
    end else begin
      row  = '1;
      sel  = 2'd0;
      badr = '1;
      wsel = 1'b0;
      sadr = '1;
    end
  endtask

  // Step i of a pass is kernel row i / if_count and feature group i % if_count + 1
  task automatic check_pass();
    logic [15:0] ky;
    logic [15:0] ifs;
    logic [47:0] exp_row;
    logic [5:0]  exp_sel;
    logic [47:0] exp_badr;
    logic [2:0]  exp_wsel;
    logic [47:0] exp_sadr;
    logic [2:0]  exp_valid;
    int          n;
    n = int'(cur.ky_count) * int'(cur.if_count);
    check_value("step_count", 48'(n), 48'(q_ky.size()));
    for (int i = 0; i < q_ky.size() && i < n; i++) begin
      ky  = 16'(i / int'(cur.if_count));
      ifs = 16'(i % int'(cur.if_count) + 1);
      for (int k = 0; k < LANES; k++) begin
        ref_lane(k, ky, ifs, exp_row[k*16 +: 16], exp_sel[k*2 +: 2], exp_badr[k*16 +: 16],
                 exp_wsel[k], exp_sadr[k*16 +: 16], exp_valid[k]);
      end
      check_value("out_ky", 48'(ky), 48'(q_ky[i]));
      check_value("out_if_start", 48'(ifs), 48'(q_if[i]));
      check_value("lane_valid", 48'(exp_valid), 48'(q_valid[i]));
      check_value("row_idx", exp_row, q_row[i]);
      check_value("buf_sel", 48'(exp_sel), 48'(q_sel[i]));
      check_value("buf_adr", exp_badr, q_badr[i]);
      check_value("word_sel", 48'(exp_wsel), 48'(q_wsel[i]));
      check_value("slab_adr", exp_sadr, q_sadr[i]);
      check_value("busy", 48'd1, 48'(q_busy[i]));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    $timeformat(-9, 0, " ns", 0);
    rst_n   <= 1'b0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= 8'd0;
    pwdata  <= 32'd0;

    // stride pad iy poy iy_start ky_count if_count nif_log2 ix_log2 restart
    cfg_tab[0] = '{4'd1, 4'd0, 16'd20, 16'd3, 16'd1, 16'd3, 16'd4, 4'd3, 4'd6, 1'b0};
    // Single output row and first two kernel rows in the top padding
    cfg_tab[1] = '{4'd1, 4'd1, 16'd16, 16'd1, 16'd0, 16'd3, 16'd2, 4'd4, 4'd5, 1'b0};
    cfg_tab[2] = '{4'd1, 4'd2, 16'd8, 16'd3, 16'd0, 16'd5, 16'd3, 4'd1, 4'd5, 1'b0};
    // Stride 2 running into the bottom padding and a second start while busy
    cfg_tab[3] = '{4'd2, 4'd1, 16'd7, 16'd3, 16'd3, 16'd3, 16'd5, 4'd2, 4'd7, 1'b1};
    cfg_tab[4] = '{4'd3, 4'd0, 16'd30, 16'd2, 16'd10, 16'd2, 16'd1, 4'd3, 4'd6, 1'b0};

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    read_check(ADR_CTRL, 32'd0, "ctrl_reset");
    read_check(ADR_STATUS, 32'd0, "status_reset");
    read_check(ADR_STRIDE, 32'd0, "stride_pad_reset");
    read_check(ADR_IY, 32'd0, "iy_reset");
    read_check(ADR_POY, 32'd0, "poy_reset");
    read_check(ADR_IY_START, 32'd0, "iy_start_reset");
    read_check(ADR_KY_COUNT, 32'd1, "ky_count_reset");
    read_check(ADR_SHAPE, 32'd0, "shape_reset");
    read_check(ADR_IF_COUNT, 32'd1, "if_count_reset");

    // Each layer once with a ready consumer and then again under random stalls
    for (int mode = 0; mode < 2; mode++) begin
      for (int e = 0; e < N_CFG; e++) begin
        cur = cfg_tab[e];
        stall_mode <= (mode == 1);
        program_cfg();
        q_ky.delete();
        q_if.delete();
        q_row.delete();
        q_sel.delete();
        q_badr.delete();
        q_wsel.delete();
        q_sadr.delete();
        q_valid.delete();
        q_busy.delete();
        apb_write(ADR_CTRL, 32'd1);
        if (cur.restart) begin
          apb_write(ADR_CTRL, 32'd1);
        end
        wait_idle();
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("adr_valid_idle", 48'd0, 48'(adr_valid));
        check_pass();
      end
    end

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
